// File: hw/timer_bus_if.sv
`default_nettype none
`timescale 1ns/100ps

module timer_bus_if
  import timer_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  // wishbone classic slave.
  input  logic                             cyc_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [ADR_W-1:0]                 adr_i,
  input  logic [SEL_W-1:0]                 sel_i,
  input  logic [DATA_W-1:0]                dat_i,
  output logic [DATA_W-1:0]                dat_o,
  output logic                             ack_o,
  // write strobes and write payload.
  output logic                             ctrl_wr_o,
  output logic                             status_wr_o,
  output logic [NUM_CHAN-1:0]              cmp_wr_o,
  output logic [NUM_CHAN-1:0]              cnt_wr_o,
  output logic [DATA_W-1:0]                wr_data_o,
  output logic [SEL_W-1:0]                 wr_sel_o,
  // read-back values.
  input  logic [DATA_W-1:0]                ctrl_i,
  input  logic [DATA_W-1:0]                status_i,
  input  logic [DATA_W-1:0]                counter_i,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0]  cmpval_i,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0]  cntval_i
);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} state_t;

  state_t            state_q;
  state_t            state_d;
  logic              req;
  logic              busy;
  logic              wr_busy;
  logic              we_q;
  logic [WORD_W-1:0] word_q;
  logic [DATA_W-1:0] wr_data_q;
  logic [SEL_W-1:0]  wr_sel_q;
  logic [DATA_W-1:0] rd_data_d;
  logic [DATA_W-1:0] rd_data_q;

  // ##########################################################
  // sequencer.

  assign req = cyc_i && stb_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
      begin
        if (req)
          state_d = S_BUSY;
      end
      S_BUSY:
        state_d = S_DONE;
      S_DONE:
        state_d = S_IDLE;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  // request is captured when idle accepts it.
  always_ff @(posedge clk_i)
  begin
    if (state_q == S_IDLE && req)
    begin
      we_q      <= we_i;
      word_q    <= adr_i[ADR_W-1:2];
      wr_data_q <= dat_i;
      wr_sel_q  <= sel_i;
    end
  end

  assign busy      = (state_q == S_BUSY);
  assign wr_busy   = busy && we_q;
  assign ack_o     = (state_q == S_DONE);
  assign wr_data_o = wr_data_q;
  assign wr_sel_o  = wr_sel_q;

  // ##########################################################
  // write decode, one strobe during busy.

  assign ctrl_wr_o   = wr_busy && (word_q == ADR_CTRL);
  assign status_wr_o = wr_busy && (word_q == ADR_STATUS);

  always_comb
  begin
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      cmp_wr_o[i] = wr_busy && (word_q == ADR_CMP_BASE + WORD_W'(i));
      cnt_wr_o[i] = wr_busy && (word_q == ADR_CNT_BASE + WORD_W'(i));
    end
  end

  // ##########################################################
  // read mux, unmapped words read as zero.

  always_comb
  begin
    case (word_q)
      ADR_CTRL:    rd_data_d = ctrl_i;
      ADR_STATUS:  rd_data_d = status_i;
      ADR_COUNTER: rd_data_d = counter_i;
      default:     rd_data_d = '0;
    endcase
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      if (word_q == ADR_CMP_BASE + WORD_W'(i))
        rd_data_d = cmpval_i[i];
      if (word_q == ADR_CNT_BASE + WORD_W'(i))
        rd_data_d = cntval_i[i];
    end
  end

  // latched at the edge that ends busy, so a counter read
  // returns the busy-cycle value.
  always_ff @(posedge clk_i)
  begin
    if (busy && !we_q)
      rd_data_q <= rd_data_d;
  end

  assign dat_o = rd_data_q;

endmodule

`default_nettype wire

// File: hw/timer_channel.sv
`default_nettype none
`timescale 1ns/100ps

module timer_channel
  import timer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [DATA_W-1:0] counter_i,
  input  logic              enable_i,
  input  logic              cmp_wr_i,
  input  logic              cnt_wr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic [SEL_W-1:0]  wr_sel_i,
  output logic              match_o,
  output logic [DATA_W-1:0] cmpval_o,
  output logic [DATA_W-1:0] cntval_o
);

  logic [DATA_W-1:0] cmpval_q;
  logic [DATA_W-1:0] cntval_q;

  // ##########################################################
  // compare register.

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      cmpval_q <= '0;
    else if (cmp_wr_i)
      cmpval_q <= byte_merge(cmpval_q, wr_data_i, wr_sel_i);
  end

  assign match_o = enable_i && (counter_i == cmpval_q);

  // ##########################################################
  // event counter.

  // a match in the same cycle overrides a software write.
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      cntval_q <= '0;
    else if (match_o)
      cntval_q <= cntval_q + 1'b1;
    else if (cnt_wr_i)
      cntval_q <= byte_merge(cntval_q, wr_data_i, wr_sel_i);
  end

  assign cmpval_o = cmpval_q;
  assign cntval_o = cntval_q;

endmodule

`default_nettype wire

// File: hw/timer_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module timer_ctrl
  import timer_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  // register writes.
  input  logic                ctrl_wr_i,
  input  logic                status_wr_i,
  input  logic [DATA_W-1:0]   wr_data_i,
  input  logic [SEL_W-1:0]    wr_sel_i,
  // channel events.
  input  logic [NUM_CHAN-1:0] match_i,
  // read-back and channel control.
  output logic [DATA_W-1:0]   ctrl_o,
  output logic [DATA_W-1:0]   status_o,
  output logic [DATA_W-1:0]   counter_o,
  output logic [NUM_CHAN-1:0] chan_en_o,
  output logic [NUM_CHAN-1:0] irq_o
);

  logic [DATA_W-1:0] counter_q;
  ctrl_word_u        ctrl_q;
  logic [DATA_W-1:0] status_q;
  logic [DATA_W-1:0] status_d;

  // ##########################################################
  // free-running counter.

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      counter_q <= '0;
    else
      counter_q <= counter_q + 1'b1;
  end

  // ##########################################################
  // control word.

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      ctrl_q.raw <= '0;
    else if (ctrl_wr_i)
      ctrl_q.raw <= byte_merge(ctrl_q.raw, wr_data_i, wr_sel_i);
  end

  assign chan_en_o = ctrl_q.f.chan_en;

  // ##########################################################
  // status.

  // written ones toggle the selected bytes, then events set.
  always_comb
  begin
    status_d = status_q;
    if (status_wr_i)
      status_d = byte_merge(status_q, status_q ^ wr_data_i, wr_sel_i);
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      if (match_i[i])
        status_d[i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      status_q <= '0;
    else
      status_q <= status_d;
  end

  // interrupts follow status and mask directly.
  assign irq_o = status_q[NUM_CHAN-1:0] & ctrl_q.f.irq_mask;

  assign ctrl_o    = ctrl_q.raw;
  assign status_o  = status_q;
  assign counter_o = counter_q;

endmodule

`default_nettype wire

// File: hw/timer_pkg.sv
`default_nettype none

package timer_pkg;

  // ##########################################################
  // sizes.
  localparam int NUM_CHAN = 4;
  localparam int DATA_W   = 32;
  localparam int SEL_W    = 4;
  localparam int ADR_W    = 6;
  // word index is adr[5:2].
  localparam int WORD_W   = ADR_W - 2;

  // ##########################################################
  // word addresses.
  localparam logic [WORD_W-1:0] ADR_CTRL     = WORD_W'(0);
  localparam logic [WORD_W-1:0] ADR_STATUS   = WORD_W'(1);
  localparam logic [WORD_W-1:0] ADR_CMP_BASE = WORD_W'(4);
  localparam logic [WORD_W-1:0] ADR_CNT_BASE = WORD_W'(8);
  localparam logic [WORD_W-1:0] ADR_COUNTER  = WORD_W'(12);

  // control word, written by byte lane and read as fields.
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [DATA_W-2*NUM_CHAN-1:0] spare;
      logic [NUM_CHAN-1:0]          irq_mask;
      logic [NUM_CHAN-1:0]          chan_en;
    } f;
  } ctrl_word_u;

  // selected bytes from new_word, the rest from old_word.
  function automatic logic [DATA_W-1:0] byte_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [SEL_W-1:0]  sel
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < SEL_W; b++)
    begin
      if (sel[b])
        merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: hw/timer_subsys.sv
`default_nettype none
`timescale 1ns/100ps

module timer_subsys
  import timer_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [ADR_W-1:0]    adr_i,
  input  logic [SEL_W-1:0]    sel_i,
  input  logic [DATA_W-1:0]   dat_i,
  output logic [DATA_W-1:0]   dat_o,
  output logic                ack_o,
  output logic [NUM_CHAN-1:0] irq_o
);

  logic                            ctrl_wr;
  logic                            status_wr;
  logic [NUM_CHAN-1:0]             cmp_wr;
  logic [NUM_CHAN-1:0]             cnt_wr;
  logic [DATA_W-1:0]               wr_data;
  logic [SEL_W-1:0]                wr_sel;
  logic [DATA_W-1:0]               ctrl;
  logic [DATA_W-1:0]               status;
  logic [DATA_W-1:0]               counter;
  logic [NUM_CHAN-1:0]             chan_en;
  logic [NUM_CHAN-1:0]             match;
  logic [NUM_CHAN-1:0][DATA_W-1:0] cmpval;
  logic [NUM_CHAN-1:0][DATA_W-1:0] cntval;

  timer_bus_if i_timer_bus_if (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .sel_i       (sel_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .ctrl_wr_o   (ctrl_wr),
    .status_wr_o (status_wr),
    .cmp_wr_o    (cmp_wr),
    .cnt_wr_o    (cnt_wr),
    .wr_data_o   (wr_data),
    .wr_sel_o    (wr_sel),
    .ctrl_i      (ctrl),
    .status_i    (status),
    .counter_i   (counter),
    .cmpval_i    (cmpval),
    .cntval_i    (cntval)
  );

  timer_ctrl i_timer_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ctrl_wr_i   (ctrl_wr),
    .status_wr_i (status_wr),
    .wr_data_i   (wr_data),
    .wr_sel_i    (wr_sel),
    .match_i     (match),
    .ctrl_o      (ctrl),
    .status_o    (status),
    .counter_o   (counter),
    .chan_en_o   (chan_en),
    .irq_o       (irq_o)
  );

  // one compare channel per interrupt bit.
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_chan
    timer_channel i_timer_channel (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .counter_i (counter),
      .enable_i  (chan_en[i]),
      .cmp_wr_i  (cmp_wr[i]),
      .cnt_wr_i  (cnt_wr[i]),
      .wr_data_i (wr_data),
      .wr_sel_i  (wr_sel),
      .match_o   (match[i]),
      .cmpval_o  (cmpval[i]),
      .cntval_o  (cntval[i])
    );
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the timer subsystem testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f timer_subsys.f \
  --top-module timer_subsys_tb \
  -o Vtimer_subsys_tb

./obj_dir/Vtimer_subsys_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"

// File: sim/timer_subsys_tb.sv
`default_nettype none
`timescale 1ns/100ps

module timer_subsys_tb
  import timer_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int SEED       = 37724;
  localparam int ACK_LIMIT  = 8;
  localparam int NUM_RAND   = 40;
  localparam int NUM_CNT_RD = 6;
  localparam int NUM_MASK   = 6;
  // bus transactions issued by the sequence below.
  localparam int NUM_TXN = 8 + 2*NUM_RAND + NUM_CNT_RD + NUM_CHAN*(3+NUM_CHAN) + NUM_MASK + 4;
  localparam int WATCHDOG_CYCLES = NUM_TXN*20 + NUM_CHAN*80 + 200;

  logic                clk_i;
  logic                rst_i;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  logic [ADR_W-1:0]    adr_i;
  logic [SEL_W-1:0]    sel_i;
  logic [DATA_W-1:0]   dat_i;
  logic [DATA_W-1:0]   dat_o;
  logic                ack_o;
  logic [NUM_CHAN-1:0] irq_o;

  int                  errors = 0;
  int unsigned         seed_state;
  logic [DATA_W-1:0]   cycle_cnt;
  // shadow registers of the DUT.
  ctrl_word_u          sh_ctrl;
  logic [DATA_W-1:0]   sh_status;
  logic [DATA_W-1:0]   sh_cmp [NUM_CHAN];
  logic [DATA_W-1:0]   sh_cnt [NUM_CHAN];
  logic [NUM_CHAN-1:0] pend;
  // reads waiting for the compare process.
  logic [DATA_W-1:0]   exp_q [$];
  logic [DATA_W-1:0]   act_q [$];
  logic [WORD_W-1:0]   rd_word_q [$];
  event                read_done;

  timer_subsys i_timer_subsys (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .sel_i (sel_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .irq_o (irq_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // mirrors the free-running counter.
  always @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + 32'd1;
  end

  // ##########################################################
  // reference model.

  function automatic logic [DATA_W-1:0] expand_sel(input logic [SEL_W-1:0] sel);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < DATA_W; b++)
      mask[b] = sel[b/8];
    return mask;
  endfunction

  function automatic void model_update(input logic [WORD_W-1:0] word,
                                       input logic [DATA_W-1:0] data,
                                       input logic [SEL_W-1:0]  sel);
    logic [DATA_W-1:0] m;
    m = expand_sel(sel);
    if (word == ADR_CTRL)
      sh_ctrl.raw = (sh_ctrl.raw & ~m) | (data & m);
    else if (word == ADR_STATUS)
      sh_status = sh_status ^ (data & m);
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      if (word == ADR_CMP_BASE + WORD_W'(i))
        sh_cmp[i] = (sh_cmp[i] & ~m) | (data & m);
      // a match in the busy cycle wins over a count write.
      if (word == ADR_CNT_BASE + WORD_W'(i) && !pend[i])
        sh_cnt[i] = (sh_cnt[i] & ~m) | (data & m);
    end
  endfunction

  // called once per cycle at the falling edge.
  // matches land one cycle late.
  function automatic void model_tick();
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      if (pend[i])
      begin
        sh_status[i] = 1'b1;
        sh_cnt[i]    = sh_cnt[i] + 32'd1;
      end
    end
    for (int i = 0; i < NUM_CHAN; i++)
      pend[i] = sh_ctrl.f.chan_en[i] && (sh_cmp[i] == cycle_cnt);
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input logic [WORD_W-1:0] word);
    if (word == ADR_CTRL)
      return sh_ctrl.raw;
    if (word == ADR_STATUS)
      return sh_status;
    if (word == ADR_COUNTER)
      return cycle_cnt;
    if (word >= ADR_CMP_BASE && word < ADR_CMP_BASE + WORD_W'(NUM_CHAN))
      return sh_cmp[int'(word - ADR_CMP_BASE)];
    if (word >= ADR_CNT_BASE && word < ADR_CNT_BASE + WORD_W'(NUM_CHAN))
      return sh_cnt[int'(word - ADR_CNT_BASE)];
    return '0;
  endfunction

  // ##########################################################
  // wishbone driver.

  task automatic close_request(input int edges, input logic acked);
    assert (acked)
    else
    begin
      errors++;
      $display("no ack from the DUT within %0d cycles at %0t", ACK_LIMIT, $time);
    end
    assert (!acked || edges == 2)
    else
    begin
      errors++;
      $display("Fail at %0t: ack_o latency expected 2 actual %0d", $time, edges);
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
    model_tick();
    assert (ack_o == 1'b0)
    else
    begin
      errors++;
      $display("Fail at %0t: ack_o expected 0 actual %b", $time, ack_o);
    end
  endtask

  task automatic wb_write(input logic [WORD_W-1:0] word, input logic [DATA_W-1:0] data,
                          input logic [SEL_W-1:0] sel);
    int          edges;
    int unsigned low;
    edges = 0;
    low   = $urandom;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = 1'b1;
    adr_i = {word, low[1:0]};
    sel_i = sel;
    dat_i = data;
    do
    begin
      @(negedge clk_i);
      edges++;
      if (ack_o)
        model_update(word, data, sel);
      model_tick();
    end
    while (!ack_o && edges < ACK_LIMIT);
    close_request(edges, ack_o);
  endtask

  task automatic wb_read(input logic [WORD_W-1:0] word);
    int                edges;
    int unsigned       low;
    logic [DATA_W-1:0] expected;
    edges    = 0;
    low      = $urandom;
    expected = '0;
    cyc_i    = 1'b1;
    stb_i    = 1'b1;
    we_i     = 1'b0;
    adr_i    = {word, low[1:0]};
    sel_i    = $urandom;
    do
    begin
      @(negedge clk_i);
      edges++;
      model_tick();
      // value of the busy cycle before ack.
      if (!ack_o)
        expected = model_read(word);
    end
    while (!ack_o && edges < ACK_LIMIT);
    if (ack_o)
    begin
      exp_q.push_back(expected);
      act_q.push_back(dat_o);
      rd_word_q.push_back(word);
      -> read_done;
    end
    close_request(edges, ack_o);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk_i);
      model_tick();
    end
  endtask

  task automatic check_irq();
    logic [NUM_CHAN-1:0] expected;
    expected = sh_status[NUM_CHAN-1:0] & sh_ctrl.f.irq_mask;
    assert (irq_o === expected)
    else
    begin
      errors++;
      $display("Fail at %0t: irq_o expected %h actual %h", $time, expected, irq_o);
    end
  endtask

  // ##########################################################
  // compare process and watchdog.

  initial
  begin : compare_reads
    forever
    begin
      @(read_done);
      while (act_q.size() > 0)
      begin
        assert (act_q[0] === exp_q[0])
        else
        begin
          errors++;
          $display("Fail at %0t: dat_o word %0d expected %h actual %h",
                   $time, rd_word_q[0], exp_q[0], act_q[0]);
        end
        void'(act_q.pop_front());
        void'(exp_q.pop_front());
        void'(rd_word_q.pop_front());
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the sequence did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ##########################################################
  // test sequence.

  initial
  begin : main_seq
    logic [WORD_W-1:0] word;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] target;
    int                pick;
    seed_state  = $urandom(SEED);
    rst_i       = 1'b1;
    cyc_i       = 1'b0;
    stb_i       = 1'b0;
    we_i        = 1'b0;
    adr_i       = '0;
    sel_i       = '0;
    dat_i       = '0;
    sh_ctrl.raw = '0;
    sh_status   = '0;
    pend        = '0;
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      sh_cmp[i] = '0;
      sh_cnt[i] = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;

    // reset values and unmapped words.
    wb_read(ADR_CTRL);
    wb_read(ADR_STATUS);
    wb_read(ADR_CNT_BASE);
    for (int w = 13; w < 16; w++)
      wb_read(WORD_W'(w));
    wb_read(WORD_W'(2));
    wb_read(WORD_W'(3));

    // byte-lane writes with channels kept off.
    for (int n = 0; n < NUM_RAND; n++)
    begin
      pick = $urandom_range(2*NUM_CHAN, 0);
      if (pick == 0)
        word = ADR_CTRL;
      else if (pick <= NUM_CHAN)
        word = ADR_CMP_BASE + WORD_W'(pick - 1);
      else
        word = ADR_CNT_BASE + WORD_W'(pick - 1 - NUM_CHAN);
      data = $urandom;
      if (word == ADR_CTRL)
        data[NUM_CHAN-1:0] = '0;
      wb_write(word, data, SEL_W'($urandom));
      wb_read(word);
    end

    for (int n = 0; n < NUM_CNT_RD; n++)
    begin
      idle_cycles($urandom_range(5, 0));
      wb_read(ADR_COUNTER);
    end

    // one channel enabled at a time with its compare point 20 to 60 cycles ahead.
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      target = cycle_cnt + $urandom_range(60, 20);
      wb_write(ADR_CMP_BASE + WORD_W'(ch), target, 4'hF);
      data = sh_ctrl.raw;
      data[NUM_CHAN-1:0] = NUM_CHAN'(1) << ch;
      wb_write(ADR_CTRL, data, 4'hF);
      while (cycle_cnt <= target + 32'd2)
        idle_cycles(1);
      wb_read(ADR_STATUS);
      for (int c = 0; c < NUM_CHAN; c++)
        wb_read(ADR_CNT_BASE + WORD_W'(c));
    end

    // random masks over the set status bits.
    for (int n = 0; n < NUM_MASK; n++)
    begin
      data = sh_ctrl.raw;
      data[2*NUM_CHAN-1:NUM_CHAN] = NUM_CHAN'($urandom);
      data[NUM_CHAN-1:0] = '0;
      wb_write(ADR_CTRL, data, 4'h1);
      check_irq();
    end
    data = sh_ctrl.raw;
    data[2*NUM_CHAN-1:NUM_CHAN] = '1;
    wb_write(ADR_CTRL, data, 4'h1);
    check_irq();
    wb_write(ADR_STATUS, 32'h5 & sh_status, 4'hF);
    check_irq();
    wb_write(ADR_STATUS, sh_status, 4'hF);
    check_irq();
    wb_read(ADR_STATUS);

    $display("sequence finished with %0d errors", errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: timer_subsys.f
hw/timer_pkg.sv
hw/timer_bus_if.sv
hw/timer_channel.sv
hw/timer_ctrl.sv
hw/timer_subsys.sv
sim/timer_subsys_tb.sv
